// ==== source/perf_pkg.sv ====
package perf_pkg;

	// processor word, used for both addresses and data
	localparam int WORD_WIDTH = 16;

	typedef logic [WORD_WIDTH-1:0] word_t;

	// eight event counters live in the window
	localparam int NUM_COUNTERS = 8;

	// highest address of the counter window
	// counters sit at consecutive words going down from here
	localparam word_t WINDOW_TOP_ADDR = 16'hFFFF;

	// counter index, equal to window top minus the address
	// FFFF is TOTAL_BR, FFF8 is L2_MISS
	typedef enum logic [2:0] {
		TOTAL_BR = 3'd0,
		BR_MISP  = 3'd1,
		IC_HIT   = 3'd2,
		IC_MISS  = 3'd3,
		DC_HIT   = 3'd4,
		DC_MISS  = 3'd5,
		L2_HIT   = 3'd6,
		L2_MISS  = 3'd7
	} counter_id_t;

	// raw event word from the pipeline and caches, one per clock
	typedef struct packed {
		logic br_in_ex;
		logic br_taken;
		logic stall;
		logic ic_hit;
		logic ic_miss;
		logic dc_hit;
		logic dc_miss;
		logic l2_hit;
		logic l2_miss;
	} perf_events_t;

	// memory-mapped request, single cycle
	typedef struct packed {
		word_t addr;
		logic  read;
		logic  write;
		word_t wdata;
	} perf_req_t;

	// read response, one cycle after the request
	typedef struct packed {
		logic  rvalid;
		word_t rdata;
	} perf_rsp_t;

endpackage : perf_pkg

// ==== source/event_qualifier.sv ====
`timescale 1ns/1ps

module event_qualifier
(
	input  logic                                clk,
	input  logic                                reset,
	input  perf_pkg::perf_events_t              events,
	output logic [perf_pkg::NUM_COUNTERS-1:0]   inc
);

	// event word held for one cycle, keeps the pipeline paths short
	perf_pkg::perf_events_t events_q;

	// stall qualifier, shared by the branch and hit counters
	logic run;

	always_ff @(posedge clk)
	begin
		if (reset)
			events_q <= '0;
		else
			events_q <= events;
	end

	always_comb
	begin
		run = ~events_q.stall;
	end

	always_comb
	begin
		inc = '0;

		// branch counters only move while the pipeline advances,
		// otherwise one branch would count for every stalled cycle
		inc[perf_pkg::TOTAL_BR] = events_q.br_in_ex & run;

		// core predicts not-taken, so every taken branch is a mispredict
		inc[perf_pkg::BR_MISP] = events_q.br_in_ex & events_q.br_taken & run;

		// hits are stall gated too
		inc[perf_pkg::IC_HIT] = events_q.ic_hit & run;
		inc[perf_pkg::DC_HIT] = events_q.dc_hit & run;

		// misses and L2 traffic count as reported
		inc[perf_pkg::IC_MISS] = events_q.ic_miss;
		inc[perf_pkg::DC_MISS] = events_q.dc_miss;
		inc[perf_pkg::L2_HIT]  = events_q.l2_hit;
		inc[perf_pkg::L2_MISS] = events_q.l2_miss;
	end

endmodule : event_qualifier

// ==== source/counter_bank.sv ====
`timescale 1ns/1ps

module counter_bank
#(
	parameter int COUNTER_WIDTH = 16
)
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic [perf_pkg::NUM_COUNTERS-1:0]   inc,
	input  logic [perf_pkg::NUM_COUNTERS-1:0]   clear,
	input  perf_pkg::counter_id_t               rd_index,
	output perf_pkg::word_t                     rd_value
);

	// one counter per event, indexed by counter_id_t
	logic [COUNTER_WIDTH-1:0] count [perf_pkg::NUM_COUNTERS];

	// clear wins over a same-cycle increment
	// counters wrap at 2**COUNTER_WIDTH
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
		begin
			if (reset || clear[i])
			begin
				count[i] <= '0;
			end
			else if (inc[i])
			begin
				count[i] <= count[i] + 1'b1;
			end
		end
	end

	// readout of the selected counter, upper bits zero
	// when the counter is narrower than a word
	always_comb
	begin
		rd_value = '0;
		rd_value[COUNTER_WIDTH-1:0] = count[rd_index];
	end

endmodule : counter_bank

// ==== source/counter_mmio_port.sv ====
`timescale 1ns/1ps

module counter_mmio_port
#(
	parameter perf_pkg::word_t WINDOW_TOP = 16'hFFFF
)
(
	input  logic                                clk,
	input  logic                                reset,
	input  perf_pkg::perf_req_t                 req,
	input  perf_pkg::word_t                     rd_value,
	output perf_pkg::counter_id_t               rd_index,
	output logic [perf_pkg::NUM_COUNTERS-1:0]   clear,
	output perf_pkg::perf_rsp_t                 rsp
);

	localparam int IDX_WIDTH = $bits(perf_pkg::counter_id_t);

	// distance from the window top, doubles as counter index
	perf_pkg::word_t offset;

	logic in_window;
	logic rd_hit;
	logic zero_store;

	// registered response
	logic            rvalid_q;
	perf_pkg::word_t rdata_q;

	// address decode
	always_comb
	begin
		offset = WINDOW_TOP - req.addr;

		// addresses above the top would wrap into a small offset
		in_window = (req.addr <= WINDOW_TOP) &&
			(offset < perf_pkg::word_t'(perf_pkg::NUM_COUNTERS));

		rd_index = perf_pkg::counter_id_t'(offset[IDX_WIDTH-1:0]);
	end

	// only a store of zero clears, any other value is dropped
	always_comb
	begin
		zero_store = req.write && in_window && (req.wdata == '0);

		clear = '0;
		if (zero_store)
		begin
			clear[rd_index] = 1'b1;
		end
	end

	always_comb
	begin
		rd_hit = req.read && in_window;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rvalid_q <= 1'b0;
		else
			rvalid_q <= rd_hit;
	end

	// rd_value is sampled before any same-edge clear takes effect,
	// so a read racing a clear returns the old count
	always_ff @(posedge clk)
	begin
		if (rd_hit)
			rdata_q <= rd_value;
	end

	always_comb
	begin
		rsp.rvalid = rvalid_q;
		rsp.rdata  = rdata_q;
	end

endmodule : counter_mmio_port

// ==== source/perf_counter_unit.sv ====
`timescale 1ns/1ps

module perf_counter_unit
#(
	parameter int              COUNTER_WIDTH = 16,
	parameter perf_pkg::word_t WINDOW_TOP    = perf_pkg::WINDOW_TOP_ADDR
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  perf_pkg::perf_events_t  events,
	input  perf_pkg::perf_req_t     req,
	output perf_pkg::perf_rsp_t     rsp
);

	// qualified per-counter increments
	logic [perf_pkg::NUM_COUNTERS-1:0] inc;

	// one-hot clear from zero stores
	logic [perf_pkg::NUM_COUNTERS-1:0] clear;

	// readout path between port and bank
	perf_pkg::counter_id_t rd_index;
	perf_pkg::word_t       rd_value;

	event_qualifier i_event_qualifier
	(
		.clk    (clk),
		.reset  (reset),
		.events (events),
		.inc    (inc)
	);

	counter_bank
	#(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	)
	i_counter_bank
	(
		.clk      (clk),
		.reset    (reset),
		.inc      (inc),
		.clear    (clear),
		.rd_index (rd_index),
		.rd_value (rd_value)
	);

	counter_mmio_port
	#(
		.WINDOW_TOP (WINDOW_TOP)
	)
	i_counter_mmio_port
	(
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.rd_value (rd_value),
		.rd_index (rd_index),
		.clear    (clear),
		.rsp      (rsp)
	);

endmodule : perf_counter_unit

// ==== test/perf_counter_unit_chk.sv ====
`timescale 1ns/1ps

module perf_counter_unit_chk
#(
	parameter int              COUNTER_WIDTH = 16,
	parameter perf_pkg::word_t WINDOW_TOP    = 16'hFFFF
)
(
	input logic                   clk,
	input logic                   reset,
	input perf_pkg::perf_events_t events,
	input perf_pkg::perf_req_t    req,
	input perf_pkg::perf_rsp_t    rsp
);

	// counter wrap mask as a word
	localparam perf_pkg::word_t CNT_MASK = perf_pkg::word_t'((32'd1 << COUNTER_WIDTH) - 1);

	// one sticky flag per assertion
	logic fail_reset  = 1'b0;
	logic fail_rvalid = 1'b0;
	logic fail_stray  = 1'b0;
	logic fail_rdata  = 1'b0;
	logic failed;

	// shadow of the pipeline event register and the counters
	perf_pkg::perf_events_t            ev_q;
	perf_pkg::word_t                   shadow [perf_pkg::NUM_COUNTERS];
	perf_pkg::word_t                   exp_rdata;
	logic [perf_pkg::NUM_COUNTERS-1:0] bump;

	// window decode of the current request
	logic            hit;
	logic [2:0]      idx;

	// eight words ending at the window top
	always_comb
	begin
		hit = (int'(req.addr) <= int'(WINDOW_TOP)) &&
			(int'(req.addr) > int'(WINDOW_TOP) - perf_pkg::NUM_COUNTERS);
		idx = 3'(WINDOW_TOP - req.addr);
	end

	// branch and hit counts hold while stalled
	// misses and L2 count regardless
	always_comb
	begin
		bump[perf_pkg::TOTAL_BR] = ev_q.br_in_ex && !ev_q.stall;
		bump[perf_pkg::BR_MISP]  = ev_q.br_in_ex && ev_q.br_taken && !ev_q.stall;
		bump[perf_pkg::IC_HIT]   = ev_q.ic_hit && !ev_q.stall;
		bump[perf_pkg::IC_MISS]  = ev_q.ic_miss;
		bump[perf_pkg::DC_HIT]   = ev_q.dc_hit && !ev_q.stall;
		bump[perf_pkg::DC_MISS]  = ev_q.dc_miss;
		bump[perf_pkg::L2_HIT]   = ev_q.l2_hit;
		bump[perf_pkg::L2_MISS]  = ev_q.l2_miss;
		failed = fail_reset || fail_rvalid || fail_stray || fail_rdata;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ev_q <= '0;
		else
			ev_q <= events;
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
		begin
			// zero store beats a same-edge increment
			if (reset || (req.write && hit && req.wdata == '0 && idx == 3'(i)))
				shadow[i] <= '0;
			else if (bump[i])
				shadow[i] <= (shadow[i] + 1'b1) & CNT_MASK;
		end
		// read sees the count from before this edge
		if (req.read && hit)
			exp_rdata <= shadow[idx];
	end

	a_quiet_after_reset: assert property (@(posedge clk) reset |=> !rsp.rvalid)
	else
	begin
		fail_reset = 1'b1;
		$error("Mismatch at %0t: rvalid high after reset", $time);
	end

	a_read_answered: assert property (@(posedge clk) disable iff (reset)
		(req.read && hit) |=> rsp.rvalid)
	else
	begin
		fail_rvalid = 1'b1;
		$error("Mismatch at %0t: window read without rvalid", $time);
	end

	a_no_stray_rvalid: assert property (@(posedge clk) disable iff (reset)
		!(req.read && hit) |=> !rsp.rvalid)
	else
	begin
		fail_stray = 1'b1;
		$error("Mismatch at %0t: rvalid without window read", $time);
	end

	a_read_value: assert property (@(posedge clk) disable iff (reset)
		rsp.rvalid |-> (rsp.rdata == exp_rdata))
	else
	begin
		fail_rdata = 1'b1;
		$error("Mismatch at %0t: rdata %h, shadow count %h", $time, rsp.rdata, exp_rdata);
	end

endmodule : perf_counter_unit_chk

// ==== test/tb_perf_counter_unit.sv ====
`timescale 1ns/1ps

module tb_perf_counter_unit;

	// cycles allowed for a read response
	localparam int RSP_TIMEOUT = 20;

	logic                   clk;
	logic                   reset;
	perf_pkg::perf_events_t events;
	perf_pkg::perf_req_t    req;
	perf_pkg::perf_rsp_t    rsp;

	perf_counter_unit i_dut
	(
		.clk    (clk),
		.reset  (reset),
		.events (events),
		.req    (req),
		.rsp    (rsp)
	);

	bind perf_counter_unit perf_counter_unit_chk
	#(
		.COUNTER_WIDTH (COUNTER_WIDTH),
		.WINDOW_TOP    (WINDOW_TOP)
	)
	i_chk
	(
		.clk    (clk),
		.reset  (reset),
		.events (events),
		.req    (req),
		.rsp    (rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// stop at the first checker failure
	always @(negedge clk)
	begin
		if (i_dut.i_chk.failed)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "checker assertion failed at %0t", $time);
		end
	end

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			req <= '0;
		end
	endtask

	// window read with an optional zero store in the same request
	task automatic read_counter(input perf_pkg::word_t address, input logic clear_too);
		int   waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		@(posedge clk);
		req <= '{addr: address, read: 1'b1, write: clear_too, wdata: '0};
		@(posedge clk);
		req <= '0;
		while (!seen && waited < RSP_TIMEOUT)
		begin
			@(negedge clk);
			seen = rsp.rvalid;
			waited++;
		end
		if (!seen)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "no read response for address %h within %0d cycles", address, RSP_TIMEOUT);
		end
	endtask

	task automatic read_all();
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			read_counter(perf_pkg::WINDOW_TOP_ADDR - perf_pkg::word_t'(i), 1'b0);
	endtask

	task automatic store(input perf_pkg::word_t address, input perf_pkg::word_t data);
		@(posedge clk);
		req <= '{addr: address, read: 1'b0, write: 1'b1, wdata: data};
		@(posedge clk);
		req <= '0;
	endtask

	// read outside the window that must not raise rvalid
	task automatic probe_outside(input perf_pkg::word_t address);
		@(posedge clk);
		req <= '{addr: address, read: 1'b1, write: 1'b0, wdata: '0};
		idle(3);
	endtask

	task automatic hold_events(input perf_pkg::perf_events_t ev, input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			events <= ev;
		end
		@(posedge clk);
		events <= '0;
	endtask

	initial
	begin
		perf_pkg::perf_events_t ev;
		logic [8:0]             ev_bits;
		logic [2:0]             pick;
		logic [2:0]             slot;
		reset = 1'b1;
		// events and a window read held in reset leave no count and no rvalid
		events = '1;
		req = '{addr: perf_pkg::WINDOW_TOP_ADDR, read: 1'b1, write: 1'b0, wdata: '0};
		void'($urandom(14632));
		repeat (3) @(posedge clk);
		req <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		events <= '0;
		idle(2);
		read_all();

		// everything high under stall
		ev = '1;
		hold_events(ev, 10);
		idle(3);
		read_all();

		// taken flag alone and then real taken branches
		ev = '0;
		ev.br_taken = 1'b1;
		hold_events(ev, 5);
		ev.br_in_ex = 1'b1;
		hold_events(ev, 3);
		idle(3);
		read_counter(16'hFFFF, 1'b0);
		read_counter(16'hFFFE, 1'b0);

		// build up hit and miss counts and clear one
		ev = '0;
		ev.ic_hit = 1'b1;
		ev.ic_miss = 1'b1;
		ev.dc_hit = 1'b1;
		ev.dc_miss = 1'b1;
		hold_events(ev, 6);
		idle(3);
		store(16'hFFFD, 16'h0000);
		store(16'hFFFC, 16'h0005);
		read_all();

		// clear lands on the last increment of a miss burst
		ev = '0;
		ev.ic_miss = 1'b1;
		@(posedge clk);
		events <= ev;
		repeat (4) @(posedge clk);
		events <= '0;
		req <= '{addr: 16'hFFFC, read: 1'b0, write: 1'b1, wdata: '0};
		@(posedge clk);
		req <= '0;
		idle(3);
		read_counter(16'hFFFC, 1'b0);

		// read and clear in one request returns the old count
		read_counter(16'hFFFA, 1'b1);
		read_counter(16'hFFFA, 1'b0);

		probe_outside(16'hFFF7);
		probe_outside(16'h1234);
		probe_outside(16'h0000);

		// random traffic on both ports
		for (int n = 0; n < 400; n++)
		begin
			@(posedge clk);
			ev_bits = 9'($urandom);
			events <= ev_bits;
			pick = 3'($urandom);
			slot = 3'($urandom);
			case (pick)
				3'd0, 3'd1:
					req <= '{addr: 16'hFFFF - perf_pkg::word_t'(slot), read: 1'b1,
						write: 1'b0, wdata: '0};
				3'd2:
					req <= '{addr: 16'hFFFF - perf_pkg::word_t'(slot), read: 1'b0,
						write: 1'b1, wdata: '0};
				3'd3:
					req <= '{addr: 16'hFFFF - perf_pkg::word_t'(slot), read: 1'b0,
						write: 1'b1, wdata: 16'($urandom) | 16'h0001};
				3'd4:
					req <= '{addr: 16'hFFF7 - perf_pkg::word_t'(slot), read: 1'b1,
						write: 1'b0, wdata: '0};
				default:
					req <= '0;
			endcase
		end
		@(posedge clk);
		events <= '0;
		req <= '0;
		idle(3);
		read_all();
		idle(3);

		if (i_dut.i_chk.failed)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "checker assertion failed");
		end
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule : tb_perf_counter_unit

// ==== build.f ====
source/perf_pkg.sv
source/event_qualifier.sv
source/counter_bank.sv
source/counter_mmio_port.sv
source/perf_counter_unit.sv
test/perf_counter_unit_chk.sv
test/tb_perf_counter_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the performance counter testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

set -u

cd "$(dirname "$0")" || exit 1

top=tb_perf_counter_unit
obj_dir=obj_dir

verilator --binary --timing --assert \
	--top-module "$top" \
	--Mdir "$obj_dir" \
	-f build.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

# checker errors are counted by the testbench, which ends the run itself
"./$obj_dir/V$top" +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

echo "simulation finished cleanly"
exit 0
